//--- src.f
source/ccu_pkg.sv
source/isa_buffer.sv
source/isa_decoder.sv
source/ccu_sequencer.sv
source/ccu_top.sv
dv/ccu_assert.sv
dv/ccu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the CCU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module ccu_tb \
    -Mdir obj_dir -o ccu_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/ccu_sim > sim.log 2>&1
sim_status=$?

if grep -q "TEST RESULT: PASS" sim.log; then
    if [ $sim_status -ne 0 ]; then
        echo "Simulation returned status $sim_status"
        exit 1
    fi
    echo "Simulation passed"
    exit 0
fi

echo "Simulation failed, see sim.log"
exit 1

//--- dv/ccu_tb.sv
// CCU table-driven testbench
`timescale 1ns/1ps

module ccu_tb;
    import ccu_pkg::*;

    localparam int isa_depth   = 8;
    localparam int n_prog      = 4;
    localparam int n_rows      = 25;
    localparam int hold_cycles = 40;  // Long stall on the last program

    // ==========================================================
    // Program table of opcodes per row
    // ==========================================================
    int tab_op [n_rows] = '{1, 3, 2, 4, 5, 1,                  // Program 1
                            5, 2, 3, 1, 2, 4, 3,               // Program 2
                            3, 4, 5, 1, 2, 3, 4, 5, 1, 3, 6, 5};
    int prog_first [n_prog] = '{0, 0, 6, 13};
    int prog_len   [n_prog] = '{0, 6, 7, 12};  // Program 0 is empty

    logic clk = 1'b0;
    logic rst_n, start, isa_valid, isa_ready;
    logic [isa_w-1:0] isa_data;
    logic sya_cfg_valid, sya_cfg_ready, pol_cfg_valid, pol_cfg_ready;
    logic ctr_cfg_valid, ctr_cfg_ready, ctr_cfg_mode, busy, done;
    logic [idx_w-1:0] sya_cfg_nip, pol_cfg_nip, ctr_cfg_nip, ctr_cfg_nop;
    logic [chn_w-1:0] sya_cfg_chi, pol_cfg_chi;
    logic [scale_w-1:0] sya_cfg_scale;
    logic [act_w-1:0] sya_cfg_shift, sya_cfg_zp;
    logic [sya_mode_w-1:0] sya_cfg_mode;
    logic [map_w-1:0] pol_cfg_k, ctr_cfg_k;

    int seed = 32'h99bd_de21;
    logic [isa_w-1:0] wq [$];          // Words of the current program
    int exp_ch_q [$];                  // 0 sya, 1 pol, 2 ctr
    logic [127:0] exp_f_q [$];
    logic [idx_w-1:0] m_nop = '0;      // Model of the kept ctr fields
    logic [map_w-1:0] m_k = '0;
    int cyc = 0, hs_cnt = 0, done_cnt = 0, last_hs_cyc = 0, done_cyc = 0;
    logic hold = 1'b0, saw_full = 1'b0;
    logic [31:0] rs, rp, rc;

    ccu_top #(.isa_depth(isa_depth)) i_dut (.*);

    bind isa_decoder ccu_assert i_assert (
        .clk(clk), .rst_n(rst_n),
        .sya_valid(sya_cfg_valid), .sya_ready(sya_cfg_ready),
        .sya_fields({sya_cfg_nip, sya_cfg_chi, sya_cfg_scale, sya_cfg_shift,
                     sya_cfg_zp, sya_cfg_mode}),
        .pol_valid(pol_cfg_valid), .pol_ready(pol_cfg_ready),
        .pol_fields({pol_cfg_nip, pol_cfg_chi, pol_cfg_k}),
        .ctr_valid(ctr_cfg_valid), .ctr_ready(ctr_cfg_ready),
        .ctr_fields({ctr_cfg_mode, ctr_cfg_nip, ctr_cfg_nop, ctr_cfg_k})
    );

    always #50 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;

    task automatic fail_msg(input string msg);
        $display("ERROR at %0t: %s", $time, msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Stopped on first error");
    endtask

    task automatic check_val(input string name, input logic [127:0] got, input logic [127:0] exp);
        assert (got === exp) else begin
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "Stopped on first error");
        end
    endtask

    function automatic logic [isa_w-1:0] rand_word();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // Reference model builds the words and expected channel results
    task automatic build_prog(input int p, output int n);
        isa_word_u u0, u1, hdr;
        logic [isa_w-1:0] t;
        int op;
        n = 0;
        wq.delete();
        for (int r = prog_first[p]; r < prog_first[p] + prog_len[p]; r++) begin
            if (tab_op[r] inside {1, 3, 4, 5}) n++;
        end
        hdr = rand_word();  // Padding stays random
        hdr.header.opcode = op_array;
        hdr.header.layers = layer_w'(n);
        wq.push_back(hdr);
        for (int r = prog_first[p]; r < prog_first[p] + prog_len[p]; r++) begin
            op = tab_op[r];
            u0 = rand_word();
            u1 = rand_word();
            t  = rand_word();  // Field values
            case (op)
                1: begin
                    u0.conv0.opcode = op_conv;
                    u0.conv0.nip = t[15:0];
                    u0.conv0.chi = t[27:16];
                    u1.conv1.opcode = op_conv;
                    u1.conv1.scale = t[52:33];
                    u1.conv1.shift = t[60:53];
                    u1.conv1.zp = t[68:61];
                    u1.conv1.mode = t[70:69];
                    wq.push_back(u0);
                    wq.push_back(u1);
                    exp_ch_q.push_back(0);
                    exp_f_q.push_back(128'({t[15:0], t[27:16], t[52:33], t[60:53],
                                            t[68:61], t[70:69]}));
                end
                3: begin
                    u0.pool.opcode = op_pool;
                    u0.pool.nip = t[15:0];
                    u0.pool.chi = t[27:16];
                    u0.pool.k = t[32:28];
                    wq.push_back(u0);
                    exp_ch_q.push_back(1);
                    exp_f_q.push_back(128'({t[15:0], t[27:16], t[32:28]}));
                end
                4: begin
                    u0.fps.opcode = op_fps;
                    u0.fps.nip = t[15:0];
                    u0.fps.nop = t[86:71];
                    m_nop = t[86:71];
                    wq.push_back(u0);
                    exp_ch_q.push_back(2);
                    exp_f_q.push_back(128'({1'b0, t[15:0], m_nop, m_k}));
                end
                5: begin
                    u0.knn.opcode = op_knn;
                    u0.knn.nip = t[15:0];
                    u0.knn.k = t[32:28];
                    m_k = t[32:28];
                    wq.push_back(u0);
                    exp_ch_q.push_back(2);
                    exp_f_q.push_back(128'({1'b1, t[15:0], m_nop, m_k}));
                end
                default: begin  // FC or unused, no layer
                    u0.header.opcode = opcode_w'(op);
                    wq.push_back(u0);
                end
            endcase
        end
    endtask

    // Host side pushes one word per valid/ready handshake
    task automatic push_word(input logic [isa_w-1:0] w);
        isa_data  = w;
        isa_valid = 1'b1;
        while (!isa_ready) @(negedge clk);
        @(negedge clk);
        isa_valid = 1'b0;
    endtask

    task automatic take(input int ch, input logic [127:0] got, input string name);
        assert (exp_ch_q.size() != 0) else fail_msg("handshake with no layer pending");
        assert (exp_ch_q[0] == ch) else fail_msg({name, " handshake on the wrong channel"});
        check_val(name, got, exp_f_q[0]);
        void'(exp_ch_q.pop_front());
        void'(exp_f_q.pop_front());
        hs_cnt++;
        last_hs_cyc = cyc + 1;  // Done due in the cycle after this handshake
    endtask

    // ==========================================================
    // Ready stall processes
    // ==========================================================
    always @(negedge clk) begin
        rs = $random(seed);
        sya_cfg_ready = !hold && (rs[1:0] != 2'd0);
    end
    always @(negedge clk) begin
        rp = $random(seed);
        pol_cfg_ready = !hold && (rp[1:0] != 2'd0);
    end
    always @(negedge clk) begin
        rc = $random(seed);
        ctr_cfg_ready = !hold && (rc[1:0] != 2'd0);
    end

    // Channel monitor sees the values the DUT samples at the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (!isa_ready) saw_full = 1'b1;
            assert ($countones({sya_cfg_valid, pol_cfg_valid, ctr_cfg_valid}) <= 1)
                else fail_msg("more than one configuration channel valid");
            if (sya_cfg_valid && sya_cfg_ready)
                take(0, 128'({sya_cfg_nip, sya_cfg_chi, sya_cfg_scale, sya_cfg_shift,
                              sya_cfg_zp, sya_cfg_mode}), "sya_cfg fields");
            if (pol_cfg_valid && pol_cfg_ready)
                take(1, 128'({pol_cfg_nip, pol_cfg_chi, pol_cfg_k}), "pol_cfg fields");
            if (ctr_cfg_valid && ctr_cfg_ready)
                take(2, 128'({ctr_cfg_mode, ctr_cfg_nip, ctr_cfg_nop, ctr_cfg_k}),
                     "ctr_cfg fields");
            if (done) begin
                done_cnt++;
                done_cyc = cyc;
            end
        end
    end

    initial begin : watchdog
        int words;
        words = n_prog + 10;
        foreach (tab_op[r]) words += (tab_op[r] == 1) ? 2 : 1;
        repeat (200 * words) @(posedge clk);
        $display("Timeout, the program table did not complete");
        $display("TEST RESULT: FAIL");
        $fatal(1, "Watchdog expired");
    end

    initial begin : main
        int n, hs0, d0;
        rst_n = 1'b0;
        start = 1'b0;
        isa_valid = 1'b0;
        isa_data = '0;
        sya_cfg_ready = 1'b0;
        pol_cfg_ready = 1'b0;
        ctr_cfg_ready = 1'b0;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        check_val("isa_ready", 128'(isa_ready), 128'(1));
        check_val("valid lines", 128'({sya_cfg_valid, pol_cfg_valid, ctr_cfg_valid}), 128'(0));
        check_val("busy", 128'(busy), 128'(0));
        check_val("done", 128'(done), 128'(0));
        for (int p = 0; p < n_prog; p++) begin
            build_prog(p, n);
            hs0 = hs_cnt;
            d0  = done_cnt;
            if (p == n_prog - 1) begin  // Fill the buffer behind a stall
                hold = 1'b1;
                fork
                    begin
                        repeat (hold_cycles) @(negedge clk);
                        hold = 1'b0;
                    end
                join_none
            end
            start = 1'b1;
            @(negedge clk);
            start = 1'b0;
            foreach (wq[i]) push_word(wq[i]);
            while (done_cnt == d0) @(negedge clk);
            check_val("handshake count", 128'(hs_cnt - hs0), 128'(n));
            check_val("pending layers", 128'(exp_ch_q.size()), 128'(0));
            if (n > 0) check_val("done cycle", 128'(done_cyc), 128'(last_hs_cyc));
            @(negedge clk);
            check_val("done", 128'(done), 128'(0));
            check_val("busy", 128'(busy), 128'(0));
            check_val("done pulses", 128'(done_cnt - d0), 128'(1));
        end
        assert (saw_full) else fail_msg("isa_ready never dropped during the long stall");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- dv/ccu_assert.sv
// CCU channel handshake assertions
`timescale 1ns/1ps

module ccu_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        sya_valid,
    input logic        sya_ready,
    input logic [65:0] sya_fields,  // nip chi scale shift zp mode
    input logic        pol_valid,
    input logic        pol_ready,
    input logic [32:0] pol_fields,  // nip chi k
    input logic        ctr_valid,
    input logic        ctr_ready,
    input logic [37:0] ctr_fields   // mode nip nop k
);

    // ==========================================================
    // Valid held until taken
    // ==========================================================
    a_sya_hold: assert property (@(posedge clk) disable iff (!rst_n)
        sya_valid && !sya_ready |=> sya_valid) else $error("sya_cfg_valid dropped early");
    a_pol_hold: assert property (@(posedge clk) disable iff (!rst_n)
        pol_valid && !pol_ready |=> pol_valid) else $error("pol_cfg_valid dropped early");
    a_ctr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        ctr_valid && !ctr_ready |=> ctr_valid) else $error("ctr_cfg_valid dropped early");

    // Fields frozen while waiting
    a_sya_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sya_valid && !sya_ready |=> $stable(sya_fields)) else $error("sya fields moved");
    a_pol_stable: assert property (@(posedge clk) disable iff (!rst_n)
        pol_valid && !pol_ready |=> $stable(pol_fields)) else $error("pol fields moved");
    a_ctr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ctr_valid && !ctr_ready |=> $stable(ctr_fields)) else $error("ctr fields moved");

    // One layer in flight
    a_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $countones({sya_valid, pol_valid, ctr_valid}) <= 1) else $error("two channels valid");
    // No word decoded while a layer waits
    a_no_pop: assert property (@(posedge clk) disable iff (!rst_n)
        (sya_valid || pol_valid || ctr_valid)
            |=> $stable({sya_fields, pol_fields, ctr_fields}))
        else $error("word decoded during layer");

endmodule

//--- source/ccu_top.sv
// Configuration control unit top
`timescale 1ns/1ps

module ccu_top #(
    parameter int isa_depth = 8   // Instruction buffer words
) (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           start,
    // Host instruction stream
    input  logic [ccu_pkg::isa_w-1:0]      isa_data,
    input  logic                           isa_valid,
    output logic                           isa_ready,
    // Systolic array
    output logic                           sya_cfg_valid,
    input  logic                           sya_cfg_ready,
    output logic [ccu_pkg::idx_w-1:0]      sya_cfg_nip,
    output logic [ccu_pkg::chn_w-1:0]      sya_cfg_chi,
    output logic [ccu_pkg::scale_w-1:0]    sya_cfg_scale,
    output logic [ccu_pkg::act_w-1:0]      sya_cfg_shift,
    output logic [ccu_pkg::act_w-1:0]      sya_cfg_zp,
    output logic [ccu_pkg::sya_mode_w-1:0] sya_cfg_mode,
    // Pooling unit
    output logic                           pol_cfg_valid,
    input  logic                           pol_cfg_ready,
    output logic [ccu_pkg::idx_w-1:0]      pol_cfg_nip,
    output logic [ccu_pkg::chn_w-1:0]      pol_cfg_chi,
    output logic [ccu_pkg::map_w-1:0]      pol_cfg_k,
    // Coordinate unit
    output logic                           ctr_cfg_valid,
    input  logic                           ctr_cfg_ready,
    output logic                           ctr_cfg_mode,
    output logic [ccu_pkg::idx_w-1:0]      ctr_cfg_nip,
    output logic [ccu_pkg::idx_w-1:0]      ctr_cfg_nop,
    output logic [ccu_pkg::map_w-1:0]      ctr_cfg_k,
    // Status
    output logic                           busy,
    output logic                           done
);
    import ccu_pkg::*;

    // Buffer to decoder
    logic [isa_w-1:0]   word;
    logic               word_valid;
    logic               word_ready;
    // Decoder and sequencer
    logic               run;
    logic               header_seen;
    logic [layer_w-1:0] layer_num;
    logic               layer_issued;

    // ==========================================================
    // Instruction buffer
    // ==========================================================
    isa_buffer #(
        .isa_depth (isa_depth)
    ) i_buffer (
        .clk, .rst_n,
        .isa_data, .isa_valid, .isa_ready,
        .word, .word_valid, .word_ready
    );

    // Decoder, drives all three channels
    isa_decoder i_decoder (
        .clk, .rst_n, .run,
        .word, .word_valid, .word_ready,
        .header_seen, .layer_num, .layer_issued,
        .sya_cfg_valid, .sya_cfg_ready, .sya_cfg_nip, .sya_cfg_chi,
        .sya_cfg_scale, .sya_cfg_shift, .sya_cfg_zp, .sya_cfg_mode,
        .pol_cfg_valid, .pol_cfg_ready, .pol_cfg_nip, .pol_cfg_chi, .pol_cfg_k,
        .ctr_cfg_valid, .ctr_cfg_ready, .ctr_cfg_mode,
        .ctr_cfg_nip, .ctr_cfg_nop, .ctr_cfg_k
    );

    // Run control
    ccu_sequencer i_sequencer (
        .clk, .rst_n, .start,
        .header_seen, .layer_num, .layer_issued,
        .run, .busy, .done
    );

endmodule

//--- source/ccu_sequencer.sv
// Program run control
`timescale 1ns/1ps

module ccu_sequencer (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        start,
    input  logic                        header_seen,   // Header popped
    input  logic [ccu_pkg::layer_w-1:0] layer_num,     // Valid with header_seen
    input  logic                        layer_issued,  // Channel handshake
    output logic                        run,
    output logic                        busy,
    output logic                        done
);
    import ccu_pkg::*;

    // FSM encoding
    localparam logic [1:0] s_idle     = 2'd0;
    localparam logic [1:0] s_wait_hdr = 2'd1;  // Header not yet popped
    localparam logic [1:0] s_layers   = 2'd2;  // Issuing layers

    logic [1:0]         state;
    logic [layer_w-1:0] layer_tgt;  // From header
    logic [layer_w-1:0] layer_cnt;  // Handshakes so far
    logic               last_layer;

    assign last_layer = layer_issued && ((layer_cnt + 1'b1) == layer_tgt);

    assign busy = (state != s_idle);
    assign run  = busy;  // Decoder pops only during a program

    // ==========================================================
    // State, counters and done pulse
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= s_idle;
            layer_tgt <= '0;
            layer_cnt <= '0;
            done      <= 1'b0;
        end else begin
            done <= 1'b0;  // Single cycle pulse
            case (state)
                s_idle: if (start) begin
                    state     <= s_wait_hdr;
                    layer_tgt <= '0;
                    layer_cnt <= '0;
                end
                s_wait_hdr: if (header_seen) begin
                    layer_tgt <= layer_num;
                    if (layer_num == '0) begin  // Empty program
                        state <= s_idle;
                        done  <= 1'b1;
                    end else begin
                        state <= s_layers;
                    end
                end
                s_layers: if (layer_issued) begin
                    layer_cnt <= layer_cnt + 1'b1;
                    if (last_layer) begin
                        state <= s_idle;
                        done  <= 1'b1;      // Busy drops with it
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

endmodule

//--- source/isa_decoder.sv
// Instruction decoder and config channels
`timescale 1ns/1ps

module isa_decoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           run,           // From sequencer
    // Word stream from the buffer
    input  logic [ccu_pkg::isa_w-1:0]      word,
    input  logic                           word_valid,
    output logic                           word_ready,
    // Sequencer events
    output logic                           header_seen,
    output logic [ccu_pkg::layer_w-1:0]    layer_num,
    output logic                           layer_issued,
    // Systolic array
    output logic                           sya_cfg_valid,
    input  logic                           sya_cfg_ready,
    output logic [ccu_pkg::idx_w-1:0]      sya_cfg_nip,
    output logic [ccu_pkg::chn_w-1:0]      sya_cfg_chi,
    output logic [ccu_pkg::scale_w-1:0]    sya_cfg_scale,
    output logic [ccu_pkg::act_w-1:0]      sya_cfg_shift,
    output logic [ccu_pkg::act_w-1:0]      sya_cfg_zp,
    output logic [ccu_pkg::sya_mode_w-1:0] sya_cfg_mode,
    // Pooling unit
    output logic                           pol_cfg_valid,
    input  logic                           pol_cfg_ready,
    output logic [ccu_pkg::idx_w-1:0]      pol_cfg_nip,
    output logic [ccu_pkg::chn_w-1:0]      pol_cfg_chi,
    output logic [ccu_pkg::map_w-1:0]      pol_cfg_k,
    // Coordinate unit
    output logic                           ctr_cfg_valid,
    input  logic                           ctr_cfg_ready,
    output logic                           ctr_cfg_mode,  // 0 FPS, 1 KNN
    output logic [ccu_pkg::idx_w-1:0]      ctr_cfg_nip,
    output logic [ccu_pkg::idx_w-1:0]      ctr_cfg_nop,
    output logic [ccu_pkg::map_w-1:0]      ctr_cfg_k
);
    import ccu_pkg::*;

    isa_word_u           iw;
    logic [opcode_w-1:0] op;
    logic                pop;
    logic                conv_cnt;  // High between conv words
    logic                sya_hs;
    logic                pol_hs;
    logic                ctr_hs;

    assign iw = word;
    assign op = iw.header.opcode;  // Same bits in every view

    // One layer in flight at most
    assign word_ready = run && !(sya_cfg_valid || pol_cfg_valid || ctr_cfg_valid);
    assign pop        = word_valid && word_ready;

    assign sya_hs = sya_cfg_valid && sya_cfg_ready;
    assign pol_hs = pol_cfg_valid && pol_cfg_ready;
    assign ctr_hs = ctr_cfg_valid && ctr_cfg_ready;

    assign layer_issued = sya_hs || pol_hs || ctr_hs;
    assign header_seen  = pop && (op == op_array);
    assign layer_num    = iw.header.layers;

    // ==========================================================
    // Field registers and valid lines
    // ==========================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            conv_cnt      <= 1'b0;
            sya_cfg_valid <= 1'b0;
            sya_cfg_nip   <= '0;
            sya_cfg_chi   <= '0;
            sya_cfg_scale <= '0;
            sya_cfg_shift <= '0;
            sya_cfg_zp    <= '0;
            sya_cfg_mode  <= '0;
            pol_cfg_valid <= 1'b0;
            pol_cfg_nip   <= '0;
            pol_cfg_chi   <= '0;
            pol_cfg_k     <= '0;
            ctr_cfg_valid <= 1'b0;
            ctr_cfg_mode  <= 1'b0;
            ctr_cfg_nip   <= '0;
            ctr_cfg_nop   <= '0;
            ctr_cfg_k     <= '0;
        end else begin
            // Drop valid once the unit takes it
            if (sya_hs) sya_cfg_valid <= 1'b0;
            if (pol_hs) pol_cfg_valid <= 1'b0;
            if (ctr_hs) ctr_cfg_valid <= 1'b0;

            if (pop) begin
                case (op)
                    op_conv: begin
                        conv_cnt <= ~conv_cnt;
                        if (!conv_cnt) begin           // First word
                            sya_cfg_nip <= iw.conv0.nip;
                            sya_cfg_chi <= iw.conv0.chi;
                        end else begin                 // Second word completes it
                            sya_cfg_scale <= iw.conv1.scale;
                            sya_cfg_shift <= iw.conv1.shift;
                            sya_cfg_zp    <= iw.conv1.zp;
                            sya_cfg_mode  <= iw.conv1.mode;
                            sya_cfg_valid <= 1'b1;
                        end
                    end
                    op_pool: begin
                        pol_cfg_nip   <= iw.pool.nip;
                        pol_cfg_chi   <= iw.pool.chi;
                        pol_cfg_k     <= iw.pool.k;
                        pol_cfg_valid <= 1'b1;
                    end
                    op_fps: begin                      // K keeps old value
                        ctr_cfg_mode  <= 1'b0;
                        ctr_cfg_nip   <= iw.fps.nip;
                        ctr_cfg_nop   <= iw.fps.nop;
                        ctr_cfg_valid <= 1'b1;
                    end
                    op_knn: begin                      // Nop keeps old value
                        ctr_cfg_mode  <= 1'b1;
                        ctr_cfg_nip   <= iw.knn.nip;
                        ctr_cfg_k     <= iw.knn.k;
                        ctr_cfg_valid <= 1'b1;
                    end
                    op_fc: begin
                        // No FC engine, word popped and dropped
                    end
                    default: begin
                        // Header handled by the sequencer, 6 and 7 dropped
                    end
                endcase
            end
        end
    end

endmodule

//--- source/isa_buffer.sv
// Instruction word FIFO
`timescale 1ns/1ps

module isa_buffer #(
    parameter int isa_depth = 8   // Power of two, at least 2
) (
    input  logic                      clk,
    input  logic                      rst_n,
    // Host write side
    input  logic [ccu_pkg::isa_w-1:0] isa_data,
    input  logic                      isa_valid,
    output logic                      isa_ready,
    // Decoder read side
    output logic [ccu_pkg::isa_w-1:0] word,
    output logic                      word_valid,
    input  logic                      word_ready
);
    import ccu_pkg::*;

    localparam int addr_w = $clog2(isa_depth);

    logic [isa_w-1:0] mem [isa_depth];  // Word storage
    logic [addr_w:0]  wr_ptr;           // Extra MSB tells full from empty
    logic [addr_w:0]  rd_ptr;
    logic [addr_w:0]  fill;             // Words held
    logic             push;
    logic             pop;

    assign fill       = wr_ptr - rd_ptr;
    assign isa_ready  = (fill != (addr_w + 1)'(isa_depth));  // Not full
    assign word_valid = (wr_ptr != rd_ptr);                   // Not empty
    assign push       = isa_valid && isa_ready;
    assign pop        = word_valid && word_ready;

    // Oldest word straight out of the array
    assign word = mem[rd_ptr[addr_w-1:0]];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[addr_w-1:0]] <= isa_data;
        end
    end

    // Pointers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;  // Wraps with the extra bit
            if (pop)  rd_ptr <= rd_ptr + 1'b1;
        end
    end

endmodule

//--- source/ccu_pkg.sv
// CCU shared definitions
package ccu_pkg;

    // ==========================================================
    // Word and field widths
    // ==========================================================
    localparam int isa_w      = 128;  // One instruction word
    localparam int opcode_w   = 3;    // Low bits of every word
    localparam int idx_w      = 16;   // Point counts nip / nop
    localparam int chn_w      = 12;   // Channel count
    localparam int map_w      = 5;    // Neighbour count K
    localparam int scale_w    = 20;
    localparam int act_w      = 8;    // Shift and zero point
    localparam int sya_mode_w = 2;
    localparam int layer_w    = 8;    // Layers per program

    // Opcodes
    localparam logic [opcode_w-1:0] op_array = 3'd0;  // Program header
    localparam logic [opcode_w-1:0] op_conv  = 3'd1;  // Two words
    localparam logic [opcode_w-1:0] op_fc    = 3'd2;  // No FC unit
    localparam logic [opcode_w-1:0] op_pool  = 3'd3;
    localparam logic [opcode_w-1:0] op_fps   = 3'd4;
    localparam logic [opcode_w-1:0] op_knn   = 3'd5;

    // Unused upper bits per layout
    localparam int hdr_pad_w   = isa_w - opcode_w - layer_w;
    localparam int conv0_pad_w = isa_w - opcode_w - idx_w - chn_w;
    localparam int conv1_pad_w = isa_w - opcode_w - scale_w - 2*act_w - sya_mode_w;
    localparam int pool_pad_w  = isa_w - opcode_w - idx_w - chn_w - map_w;
    localparam int fps_pad_w   = isa_w - opcode_w - 2*idx_w;
    localparam int knn_pad_w   = isa_w - opcode_w - idx_w - map_w;

    // ==========================================================
    // Word layouts, listed MSB first so opcode lands at bit 0
    // ==========================================================
    typedef struct packed {
        logic [hdr_pad_w-1:0]   pad;
        logic [layer_w-1:0]     layers;
        logic [opcode_w-1:0]    opcode;
    } hdr_view_t;

    typedef struct packed {
        logic [conv0_pad_w-1:0] pad;
        logic [chn_w-1:0]       chi;
        logic [idx_w-1:0]       nip;
        logic [opcode_w-1:0]    opcode;
    } conv0_view_t;

    typedef struct packed {
        logic [conv1_pad_w-1:0] pad;
        logic [sya_mode_w-1:0]  mode;
        logic [act_w-1:0]       zp;
        logic [act_w-1:0]       shift;
        logic [scale_w-1:0]     scale;
        logic [opcode_w-1:0]    opcode;
    } conv1_view_t;

    typedef struct packed {
        logic [pool_pad_w-1:0]  pad;
        logic [map_w-1:0]       k;
        logic [chn_w-1:0]       chi;
        logic [idx_w-1:0]       nip;
        logic [opcode_w-1:0]    opcode;
    } pool_view_t;

    typedef struct packed {
        logic [fps_pad_w-1:0]   pad;
        logic [idx_w-1:0]       nop;  // Sampled point count
        logic [idx_w-1:0]       nip;
        logic [opcode_w-1:0]    opcode;
    } fps_view_t;

    typedef struct packed {
        logic [knn_pad_w-1:0]   pad;
        logic [map_w-1:0]       k;
        logic [idx_w-1:0]       nip;
        logic [opcode_w-1:0]    opcode;
    } knn_view_t;

    // One word, decoded by its opcode
    typedef union packed {
        hdr_view_t   header;
        conv0_view_t conv0;
        conv1_view_t conv1;
        pool_view_t  pool;
        fps_view_t   fps;
        knn_view_t   knn;
    } isa_word_u;

endpackage
